// File: sim.f
+incdir+src
src/apu_pkg.sv
src/apu_core_router.sv
src/apu_arbiter.sv
src/apu_int_mult.sv
src/apu_int_div.sv
src/apu_cluster.sv
sim/apu_cluster_tb.sv

// File: sim/apu_cluster_tb.sv
//////////////////////////////
// Self-checking testbench for the shared unit cluster. Needs
// apu_defines.svh on the include path. Random stimulus is
// reproducible from one fixed seed
//////////////////////////////

`timescale 1ns/1ps

`include "apu_defines.svh"

`default_nettype none

module apu_cluster_tb;

   localparam int NB           = `APU_NB_CORES;
   localparam int W            = `APU_DATA_W;
   localparam int STAGES       = `APU_MULT_STAGES;
   localparam int IDLE_CYCLES  = 8;
   localparam int DIV_DIRECTED = 8;
   localparam int N_RAND       = 20;
   localparam int TOTAL_REQS   = 2 + DIV_DIRECTED + NB * 2 * N_RAND;
   localparam int WATCHDOG     = TOTAL_REQS * NB * (W + 4) + IDLE_CYCLES + 16;

   logic                clk_i;
   logic                rst_i;
   logic                req_valid_i  [NB];
   logic                req_ready_o  [NB];
   apu_pkg::apu_type_e  req_type_i   [NB];
   logic                req_op_i     [NB];
   apu_pkg::data_t      req_a_i      [NB];
   apu_pkg::data_t      req_b_i      [NB];
   logic                rsp_valid_o  [NB];
   logic                rsp_ready_i  [NB];
   apu_pkg::data_t      rsp_result_o [NB];

   // Pre-generated random traffic, two batches per core
   apu_pkg::apu_type_e  stim_type [NB][2*N_RAND];
   logic                stim_op   [NB][2*N_RAND];
   apu_pkg::data_t      stim_a    [NB][2*N_RAND];
   apu_pkg::data_t      stim_b    [NB][2*N_RAND];
   int                  stim_gap  [NB][2*N_RAND];

   apu_pkg::data_t      exp_q [NB][$];
   int                  sent_cnt [NB];
   int                  seed;
   int                  phase = 0;
   logic                ready_random = 1'b0;
   logic [NB-1:0]       done_mix = '0;
   logic [NB-1:0]       done_stall = '0;

   apu_cluster i_apu_cluster (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_valid_i  (req_valid_i),
      .req_ready_o  (req_ready_o),
      .req_type_i   (req_type_i),
      .req_op_i     (req_op_i),
      .req_a_i      (req_a_i),
      .req_b_i      (req_b_i),
      .rsp_valid_o  (rsp_valid_o),
      .rsp_ready_i  (rsp_ready_i),
      .rsp_result_o (rsp_result_o)
   );

   always #50 clk_i = ~clk_i;

   //////////////////////////////
   // Reference model and checks
   //////////////////////////////

   function automatic apu_pkg::data_t apu_ref(input apu_pkg::apu_type_e t, input logic op,
                                              input apu_pkg::data_t a, input apu_pkg::data_t b);
      logic [2*W-1:0] prod;
      if (t == apu_pkg::APU_TYPE_MULT) begin
         prod = {{W{1'b0}}, a} * {{W{1'b0}}, b};
         return op ? prod[2*W-1:W] : prod[W-1:0];
      end
      // Divide by zero: all ones quotient, dividend as remainder
      if (b == '0) begin
         return op ? a : '1;
      end
      return op ? (a % b) : (a / b);
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(input apu_pkg::data_t got, input apu_pkg::data_t exp,
                        input string what);
      if (got !== exp) begin
         abort_run($sformatf("error at %0t ns: %s, got %h, expected %h",
                             $time, what, got, exp));
      end
   endtask

   function automatic bit queues_empty();
      for (int c = 0; c < NB; c++) begin
         if (exp_q[c].size() != 0) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   function automatic int total_sent();
      int sum;
      sum = 0;
      for (int c = 0; c < NB; c++) begin
         sum += sent_cnt[c];
      end
      return sum;
   endfunction

   // Pops the expected value on every response transfer
   always @(posedge clk_i) begin
      apu_pkg::data_t exp;
      if (!rst_i) begin
         for (int c = 0; c < NB; c++) begin
            if (rsp_valid_o[c] && rsp_ready_i[c]) begin
               if (exp_q[c].size() == 0) begin
                  abort_run($sformatf("core %0d got a response it never asked for", c));
               end else begin
                  exp = exp_q[c].pop_front();
                  check(rsp_result_o[c], exp, $sformatf("core %0d result", c));
               end
            end
         end
      end
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   task automatic gen_stimulus();
      int sel;
      for (int c = 0; c < NB; c++) begin
         for (int i = 0; i < 2 * N_RAND; i++) begin
            stim_type[c][i] = ($random(seed) & 1) ? apu_pkg::APU_TYPE_DIV
                                                  : apu_pkg::APU_TYPE_MULT;
            stim_op[c][i]   = $random(seed) & 1;
            stim_a[c][i]    = $random(seed);
            sel             = $unsigned($random(seed)) % 8;
            // Mix of zero, narrow and full width divisors
            if (sel == 0) begin
               stim_b[c][i] = '0;
            end else begin
               stim_b[c][i] = apu_pkg::data_t'($random(seed)) >> (sel * 4 - 4);
            end
            stim_gap[c][i]  = $unsigned($random(seed)) % 4;
         end
      end
   endtask

   // Called with the clock anywhere, returns at the falling edge after the transfer
   task automatic issue_req(input int c, input apu_pkg::apu_type_e t, input logic op,
                            input apu_pkg::data_t a, input apu_pkg::data_t b);
      @(negedge clk_i);
      req_valid_i[c] = 1'b1;
      req_type_i[c]  = t;
      req_op_i[c]    = op;
      req_a_i[c]     = a;
      req_b_i[c]     = b;
      do begin
         @(posedge clk_i);
      end while (!req_ready_o[c]);
      exp_q[c].push_back(apu_ref(t, op, a, b));
      sent_cnt[c]++;
      @(negedge clk_i);
      req_valid_i[c] = 1'b0;
   endtask

   task automatic run_batch(input int c, input int base);
      for (int i = base; i < base + N_RAND; i++) begin
         repeat (stim_gap[c][i]) @(negedge clk_i);
         issue_req(c, stim_type[c][i], stim_op[c][i], stim_a[c][i], stim_b[c][i]);
      end
   endtask

   // Multiply from core 0 alone, counting edges up to the response
   task automatic mult_latency(input logic op, input apu_pkg::data_t a,
                               input apu_pkg::data_t b);
      int n;
      n = 0;
      issue_req(0, apu_pkg::APU_TYPE_MULT, op, a, b);
      do begin
         @(posedge clk_i);
         n++;
      end while (!rsp_valid_o[0] && n < 64);
      check(n, STAGES, "multiply latency in cycles");
   endtask

   for (genvar c = 0; c < NB; c++) begin : g_core
      initial begin
         wait (phase == 4);
         run_batch(c, 0);
         done_mix[c] = 1'b1;
         wait (phase == 5);
         run_batch(c, N_RAND);
         done_stall[c] = 1'b1;
      end
   end

   // Response back-pressure, random per core in the last phase
   always @(negedge clk_i) begin
      for (int c = 0; c < NB; c++) begin
         rsp_ready_i[c] = ready_random ? ($random(seed) & 1) : 1'b1;
      end
   end

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      apu_pkg::data_t a;
      apu_pkg::data_t b;
      seed  = 68187;
      clk_i = 1'b0;
      rst_i = 1'b1;
      for (int c = 0; c < NB; c++) begin
         req_valid_i[c] = 1'b0;
         req_type_i[c]  = apu_pkg::APU_TYPE_MULT;
         req_op_i[c]    = 1'b0;
         req_a_i[c]     = '0;
         req_b_i[c]     = '0;
         rsp_ready_i[c] = 1'b1;
         sent_cnt[c]    = 0;
      end
      gen_stimulus();
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;

      // Quiet after reset
      repeat (IDLE_CYCLES) begin
         @(posedge clk_i);
         for (int c = 0; c < NB; c++) begin
            check(rsp_valid_o[c], '0, $sformatf("core %0d response valid while idle", c));
         end
      end

      mult_latency(1'b0, 32'hFFFF_FFFD, 32'h8000_0007);
      mult_latency(1'b1, 32'hFFFF_FFFD, 32'h8000_0007);

      // Directed divides, the first two by zero
      for (int i = 0; i < DIV_DIRECTED; i++) begin
         a = $random(seed);
         if (i < 2) begin
            b = '0;
         end else if (i == 2) begin
            b = 32'hFFFF_FFFF;
         end else begin
            b = apu_pkg::data_t'($random(seed)) >> (i * 3);
         end
         issue_req(0, apu_pkg::APU_TYPE_DIV, i[0], a, b);
      end

      phase = 4;
      wait (done_mix == '1);
      ready_random = 1'b1;
      phase = 5;
      wait (done_stall == '1);
      while (!queues_empty()) begin
         @(posedge clk_i);
      end
      ready_random = 1'b0;
      // Extra cycles catch a duplicated response
      repeat (IDLE_CYCLES) @(posedge clk_i);

      if (queues_empty() && total_sent() == TOTAL_REQS) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         abort_run($sformatf("only %0d of %0d requests were sent and answered",
                             total_sent(), TOTAL_REQS));
      end
   end

   initial begin
      repeat (WATCHDOG) @(posedge clk_i);
      abort_run($sformatf("run timed out after %0d cycles", WATCHDOG));
   end

endmodule

`default_nettype wire

// File: src/apu_arbiter.sv
//////////////////////////////
// Round-robin arbiter for one shared unit. Relies on the core
// count being a power of two for pointer wrap-around
//////////////////////////////

`timescale 1ns/1ps

`include "apu_defines.svh"

`default_nettype none

module apu_arbiter (
   input  logic               clk_i,
   input  logic               rst_i,
   // Core side
   input  logic               core_valid_i     [`APU_NB_CORES],
   output logic               core_ready_o     [`APU_NB_CORES],
   input  apu_pkg::op_sel_t   core_op_i        [`APU_NB_CORES],
   input  apu_pkg::data_t     core_a_i         [`APU_NB_CORES],
   input  apu_pkg::data_t     core_b_i         [`APU_NB_CORES],
   output logic               core_rsp_valid_o [`APU_NB_CORES],
   input  logic               core_rsp_ready_i [`APU_NB_CORES],
   output apu_pkg::data_t     core_result_o    [`APU_NB_CORES],
   // Unit side
   output logic               in_valid_o,
   input  logic               in_ready_i,
   output apu_pkg::core_tag_t in_tag_o,
   output apu_pkg::op_sel_t   in_op_o,
   output apu_pkg::data_t     in_a_o,
   output apu_pkg::data_t     in_b_o,
   input  logic               out_valid_i,
   output logic               out_ready_o,
   input  apu_pkg::core_tag_t out_tag_i,
   input  apu_pkg::data_t     out_result_i
);

   localparam int NB = `APU_NB_CORES;

   apu_pkg::core_tag_t ptr_q;
   apu_pkg::core_tag_t grant_idx;
   logic               grant_found;
   logic [NB-1:0]      ready_vec;

   //////////////////////////////
   // Grant
   //////////////////////////////

   // First requesting core at or after the pointer
   always_comb begin
      apu_pkg::core_tag_t idx;
      grant_found = 1'b0;
      grant_idx   = ptr_q;
      ready_vec   = '0;
      for (int i = 0; i < NB; i++) begin
         idx = apu_pkg::core_tag_t'(ptr_q + i);
         if (!grant_found && core_valid_i[idx]) begin
            grant_found    = 1'b1;
            grant_idx      = idx;
            ready_vec[idx] = in_ready_i;
         end
      end
   end

   assign in_valid_o = grant_found;
   assign in_tag_o   = grant_idx;
   assign in_op_o    = core_op_i[grant_idx];
   assign in_a_o     = core_a_i[grant_idx];
   assign in_b_o     = core_b_i[grant_idx];

   // Pointer moves past the winner on each unit transfer
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ptr_q <= '0;
      end else if (in_valid_o && in_ready_i) begin
         ptr_q <= grant_idx + 1'b1;
      end
   end

   //////////////////////////////
   // Per-core handshakes
   //////////////////////////////

   for (genvar c = 0; c < NB; c++) begin : g_core
      assign core_ready_o[c] = ready_vec[c];

      // Result goes back to the tagged core only
      assign core_rsp_valid_o[c] = out_valid_i && (out_tag_i == apu_pkg::core_tag_t'(c));
      assign core_result_o[c]    = out_result_i;
   end

   assign out_ready_o = core_rsp_ready_i[out_tag_i];

   assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(ready_vec));

endmodule

`default_nettype wire

// File: src/apu_cluster.sv
//////////////////////////////
// Shared multiply and divide units for all cores. Each core may
// keep only one request outstanding at a time
//////////////////////////////

`timescale 1ns/1ps

`include "apu_defines.svh"

`default_nettype none

module apu_cluster (
   input  logic               clk_i,
   input  logic               rst_i,
   // Request channel per core
   input  logic               req_valid_i  [`APU_NB_CORES],
   output logic               req_ready_o  [`APU_NB_CORES],
   input  apu_pkg::apu_type_e req_type_i   [`APU_NB_CORES],
   input  apu_pkg::op_sel_t   req_op_i     [`APU_NB_CORES],
   input  apu_pkg::data_t     req_a_i      [`APU_NB_CORES],
   input  apu_pkg::data_t     req_b_i      [`APU_NB_CORES],
   // Response channel per core
   output logic               rsp_valid_o  [`APU_NB_CORES],
   input  logic               rsp_ready_i  [`APU_NB_CORES],
   output apu_pkg::data_t     rsp_result_o [`APU_NB_CORES]
);

   // Router to arbiter, per core
   logic               mult_valid      [`APU_NB_CORES];
   logic               div_valid       [`APU_NB_CORES];
   apu_pkg::op_sel_t   core_op         [`APU_NB_CORES];
   apu_pkg::data_t     core_a          [`APU_NB_CORES];
   apu_pkg::data_t     core_b          [`APU_NB_CORES];
   logic               mult_ready      [`APU_NB_CORES];
   logic               div_ready       [`APU_NB_CORES];
   logic               mult_rsp_valid  [`APU_NB_CORES];
   logic               div_rsp_valid   [`APU_NB_CORES];
   logic               mult_rsp_ready  [`APU_NB_CORES];
   logic               div_rsp_ready   [`APU_NB_CORES];
   apu_pkg::data_t     mult_result     [`APU_NB_CORES];
   apu_pkg::data_t     div_result      [`APU_NB_CORES];

   // Arbiter to unit
   logic               mu_in_valid;
   logic               mu_in_ready;
   apu_pkg::core_tag_t mu_in_tag;
   apu_pkg::op_sel_t   mu_in_op;
   apu_pkg::data_t     mu_in_a;
   apu_pkg::data_t     mu_in_b;
   logic               mu_out_valid;
   logic               mu_out_ready;
   apu_pkg::core_tag_t mu_out_tag;
   apu_pkg::data_t     mu_out_result;

   logic               dv_in_valid;
   logic               dv_in_ready;
   apu_pkg::core_tag_t dv_in_tag;
   apu_pkg::op_sel_t   dv_in_op;
   apu_pkg::data_t     dv_in_a;
   apu_pkg::data_t     dv_in_b;
   logic               dv_out_valid;
   logic               dv_out_ready;
   apu_pkg::core_tag_t dv_out_tag;
   apu_pkg::data_t     dv_out_result;

   //////////////////////////////
   // Per-core routers
   //////////////////////////////

   for (genvar c = 0; c < `APU_NB_CORES; c++) begin : g_router
      apu_core_router i_router (
         .clk_i            (clk_i),
         .rst_i            (rst_i),
         .req_valid_i      (req_valid_i[c]),
         .req_ready_o      (req_ready_o[c]),
         .req_type_i       (req_type_i[c]),
         .req_op_i         (req_op_i[c]),
         .req_a_i          (req_a_i[c]),
         .req_b_i          (req_b_i[c]),
         .rsp_valid_o      (rsp_valid_o[c]),
         .rsp_ready_i      (rsp_ready_i[c]),
         .rsp_result_o     (rsp_result_o[c]),
         .mult_valid_o     (mult_valid[c]),
         .div_valid_o      (div_valid[c]),
         .op_o             (core_op[c]),
         .a_o              (core_a[c]),
         .b_o              (core_b[c]),
         .mult_ready_i     (mult_ready[c]),
         .div_ready_i      (div_ready[c]),
         .mult_rsp_valid_i (mult_rsp_valid[c]),
         .div_rsp_valid_i  (div_rsp_valid[c]),
         .mult_result_i    (mult_result[c]),
         .div_result_i     (div_result[c]),
         .mult_rsp_ready_o (mult_rsp_ready[c]),
         .div_rsp_ready_o  (div_rsp_ready[c])
      );
   end

   //////////////////////////////
   // Multiplier path
   //////////////////////////////

   apu_arbiter i_mult_arbiter (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .core_valid_i     (mult_valid),
      .core_ready_o     (mult_ready),
      .core_op_i        (core_op),
      .core_a_i         (core_a),
      .core_b_i         (core_b),
      .core_rsp_valid_o (mult_rsp_valid),
      .core_rsp_ready_i (mult_rsp_ready),
      .core_result_o    (mult_result),
      .in_valid_o       (mu_in_valid),
      .in_ready_i       (mu_in_ready),
      .in_tag_o         (mu_in_tag),
      .in_op_o          (mu_in_op),
      .in_a_o           (mu_in_a),
      .in_b_o           (mu_in_b),
      .out_valid_i      (mu_out_valid),
      .out_ready_o      (mu_out_ready),
      .out_tag_i        (mu_out_tag),
      .out_result_i     (mu_out_result)
   );

   apu_int_mult i_int_mult (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .in_valid_i   (mu_in_valid),
      .in_ready_o   (mu_in_ready),
      .in_tag_i     (mu_in_tag),
      .in_op_i      (mu_in_op),
      .in_a_i       (mu_in_a),
      .in_b_i       (mu_in_b),
      .out_valid_o  (mu_out_valid),
      .out_ready_i  (mu_out_ready),
      .out_tag_o    (mu_out_tag),
      .out_result_o (mu_out_result)
   );

   //////////////////////////////
   // Divider path
   //////////////////////////////

   apu_arbiter i_div_arbiter (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .core_valid_i     (div_valid),
      .core_ready_o     (div_ready),
      .core_op_i        (core_op),
      .core_a_i         (core_a),
      .core_b_i         (core_b),
      .core_rsp_valid_o (div_rsp_valid),
      .core_rsp_ready_i (div_rsp_ready),
      .core_result_o    (div_result),
      .in_valid_o       (dv_in_valid),
      .in_ready_i       (dv_in_ready),
      .in_tag_o         (dv_in_tag),
      .in_op_o          (dv_in_op),
      .in_a_o           (dv_in_a),
      .in_b_o           (dv_in_b),
      .out_valid_i      (dv_out_valid),
      .out_ready_o      (dv_out_ready),
      .out_tag_i        (dv_out_tag),
      .out_result_i     (dv_out_result)
   );

   apu_int_div i_int_div (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .in_valid_i   (dv_in_valid),
      .in_ready_o   (dv_in_ready),
      .in_tag_i     (dv_in_tag),
      .in_op_i      (dv_in_op),
      .in_a_i       (dv_in_a),
      .in_b_i       (dv_in_b),
      .out_valid_o  (dv_out_valid),
      .out_ready_i  (dv_out_ready),
      .out_tag_o    (dv_out_tag),
      .out_result_o (dv_out_result)
   );

endmodule

`default_nettype wire

// File: src/apu_core_router.sv
//////////////////////////////
// Steers one core's requests by unit type. A new request is only
// taken once the previous response has been consumed
//////////////////////////////

`timescale 1ns/1ps

`default_nettype none

module apu_core_router (
   input  logic               clk_i,
   input  logic               rst_i,
   // Core side
   input  logic               req_valid_i,
   output logic               req_ready_o,
   input  apu_pkg::apu_type_e req_type_i,
   input  apu_pkg::op_sel_t   req_op_i,
   input  apu_pkg::data_t     req_a_i,
   input  apu_pkg::data_t     req_b_i,
   output logic               rsp_valid_o,
   input  logic               rsp_ready_i,
   output apu_pkg::data_t     rsp_result_o,
   // Arbiter side
   output logic               mult_valid_o,
   output logic               div_valid_o,
   output apu_pkg::op_sel_t   op_o,
   output apu_pkg::data_t     a_o,
   output apu_pkg::data_t     b_o,
   input  logic               mult_ready_i,
   input  logic               div_ready_i,
   input  logic               mult_rsp_valid_i,
   input  logic               div_rsp_valid_i,
   input  apu_pkg::data_t     mult_result_i,
   input  apu_pkg::data_t     div_result_i,
   output logic               mult_rsp_ready_o,
   output logic               div_rsp_ready_o
);

   logic outstanding_q;
   logic is_mult;

   assign is_mult = (req_type_i == apu_pkg::APU_TYPE_MULT);

   // Request steering
   assign mult_valid_o = req_valid_i && !outstanding_q && is_mult;
   assign div_valid_o  = req_valid_i && !outstanding_q && !is_mult;
   assign req_ready_o  = !outstanding_q && (is_mult ? mult_ready_i : div_ready_i);

   // Payload goes to both arbiters, only one sees a valid
   assign op_o = req_op_i;
   assign a_o  = req_a_i;
   assign b_o  = req_b_i;

   // Response merge
   assign rsp_valid_o      = mult_rsp_valid_i || div_rsp_valid_i;
   assign rsp_result_o     = mult_rsp_valid_i ? mult_result_i : div_result_i;
   assign mult_rsp_ready_o = rsp_ready_i;
   assign div_rsp_ready_o  = rsp_ready_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         outstanding_q <= 1'b0;
      end else if (rsp_valid_o && rsp_ready_i) begin
         outstanding_q <= 1'b0;
      end else if (req_valid_i && req_ready_o) begin
         outstanding_q <= 1'b1;
      end
   end

   // One request in flight, so both units never answer this core at once
   assert property (@(posedge clk_i) disable iff (rst_i)
      !(mult_rsp_valid_i && div_rsp_valid_i));

endmodule

`default_nettype wire

// File: src/apu_defines.svh
//////////////////////////////
// Cluster-wide sizes. The core count must be a power of two
// from 2 to 8, and the multiplier depth must be at least 1
//////////////////////////////

`ifndef APU_DEFINES_SVH
`define APU_DEFINES_SVH

// Number of cores sharing the units
`define APU_NB_CORES 4

// Operand and result width
`define APU_DATA_W 32

// Register stages in the integer multiplier
`define APU_MULT_STAGES 2

`endif

// File: src/apu_int_div.sv
//////////////////////////////
// Restoring unsigned divider, one quotient bit per cycle.
// Takes a new operand pair only in IDLE
//////////////////////////////

`timescale 1ns/1ps

`include "apu_defines.svh"

`default_nettype none

module apu_int_div (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               in_valid_i,
   output logic               in_ready_o,
   input  apu_pkg::core_tag_t in_tag_i,
   input  apu_pkg::op_sel_t   in_op_i,
   input  apu_pkg::data_t     in_a_i,
   input  apu_pkg::data_t     in_b_i,
   output logic               out_valid_o,
   input  logic               out_ready_i,
   output apu_pkg::core_tag_t out_tag_o,
   output apu_pkg::data_t     out_result_o
);

   localparam int W     = `APU_DATA_W;
   localparam int CNT_W = $clog2(W);
   localparam int BUSY  = W + 1;

   apu_pkg::div_state_e state_q;
   apu_pkg::data_t      dvd_q;
   apu_pkg::data_t      dvs_q;
   apu_pkg::data_t      rem_q;
   apu_pkg::core_tag_t  tag_q;
   apu_pkg::op_sel_t    op_q;
   logic [CNT_W-1:0]    cnt_q;
   logic [W:0]          shifted;
   logic [W:0]          diff;

   // Trial subtraction, top bit set means borrow
   assign shifted = {rem_q, dvd_q[W-1]};
   assign diff    = shifted - {1'b0, dvs_q};

   //////////////////////////////
   // Control FSM
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= apu_pkg::IDLE;
      end else begin
         case (state_q)
            apu_pkg::IDLE: begin
               if (in_valid_i) begin
                  state_q <= apu_pkg::RUN;
               end
            end
            apu_pkg::RUN: begin
               if (cnt_q == CNT_W'(W-1)) begin
                  state_q <= apu_pkg::DONE;
               end
            end
            apu_pkg::DONE: begin
               if (out_ready_i) begin
                  state_q <= apu_pkg::IDLE;
               end
            end
            default: state_q <= apu_pkg::IDLE;
         endcase
      end
   end

   //////////////////////////////
   // Datapath
   //////////////////////////////

   // Dividend register fills with quotient bits from the right.
   // A zero divisor never borrows, giving all ones and the dividend
   always_ff @(posedge clk_i) begin
      if (state_q == apu_pkg::IDLE && in_valid_i) begin
         dvd_q <= in_a_i;
         dvs_q <= in_b_i;
         rem_q <= '0;
         cnt_q <= '0;
         tag_q <= in_tag_i;
         op_q  <= in_op_i;
      end else if (state_q == apu_pkg::RUN) begin
         cnt_q <= cnt_q + 1'b1;
         rem_q <= diff[W] ? shifted[W-1:0] : diff[W-1:0];
         dvd_q <= {dvd_q[W-2:0], !diff[W]};
      end
   end

   assign in_ready_o   = (state_q == apu_pkg::IDLE);
   assign out_valid_o  = (state_q == apu_pkg::DONE);
   assign out_tag_o    = tag_q;
   assign out_result_o = op_q ? rem_q : dvd_q;

   // Busy for the full iteration plus the result cycle
   assert property (@(posedge clk_i) disable iff (rst_i)
      (in_valid_i && in_ready_o) |=> !in_ready_o [*BUSY]);

endmodule

`default_nettype wire

// File: src/apu_int_mult.sv
//////////////////////////////
// Unsigned 32x32 multiplier, fixed depth. The whole pipeline
// stalls when the output is blocked, bubbles are not squeezed
//////////////////////////////

`timescale 1ns/1ps

`include "apu_defines.svh"

`default_nettype none

module apu_int_mult (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               in_valid_i,
   output logic               in_ready_o,
   input  apu_pkg::core_tag_t in_tag_i,
   input  apu_pkg::op_sel_t   in_op_i,
   input  apu_pkg::data_t     in_a_i,
   input  apu_pkg::data_t     in_b_i,
   output logic               out_valid_o,
   input  logic               out_ready_i,
   output apu_pkg::core_tag_t out_tag_o,
   output apu_pkg::data_t     out_result_o
);

   localparam int W = `APU_DATA_W;
   localparam int S = `APU_MULT_STAGES;

   typedef logic [2*W-1:0] prod_t;

   logic [S-1:0]       valid_q;
   apu_pkg::core_tag_t tag_q  [S];
   apu_pkg::op_sel_t   op_q   [S];
   prod_t              prod_q [S];
   logic               adv;

   // Advance unless the last stage holds an unaccepted result
   assign adv        = !(valid_q[S-1] && !out_ready_i);
   assign in_ready_o = adv;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_q <= '0;
      end else if (adv) begin
         valid_q[0] <= in_valid_i;
         for (int s = 1; s < S; s++) begin
            valid_q[s] <= valid_q[s-1];
         end
      end
   end

   // Full product formed in the first stage, then carried along
   always_ff @(posedge clk_i) begin
      if (adv) begin
         tag_q[0]  <= in_tag_i;
         op_q[0]   <= in_op_i;
         prod_q[0] <= prod_t'(in_a_i) * prod_t'(in_b_i);
         for (int s = 1; s < S; s++) begin
            tag_q[s]  <= tag_q[s-1];
            op_q[s]   <= op_q[s-1];
            prod_q[s] <= prod_q[s-1];
         end
      end
   end

   assign out_valid_o  = valid_q[S-1];
   assign out_tag_o    = tag_q[S-1];
   assign out_result_o = op_q[S-1] ? prod_q[S-1][2*W-1:W] : prod_q[S-1][W-1:0];

   assert property (@(posedge clk_i) disable iff (rst_i)
      (out_valid_o && !out_ready_i) |=>
         (out_valid_o && $stable(out_result_o) && $stable(out_tag_o)));

endmodule

`default_nettype wire

// File: src/apu_pkg.sv
//////////////////////////////
// Shared types of the cluster. Widths follow apu_defines.svh
//////////////////////////////

`include "apu_defines.svh"

`default_nettype none

package apu_pkg;

   // Operand or result word
   typedef logic [`APU_DATA_W-1:0] data_t;

   // Index of the issuing core
   typedef logic [$clog2(`APU_NB_CORES)-1:0] core_tag_t;

   // Mult: 0 low word, 1 high word
   // Div: 0 quotient, 1 remainder
   typedef logic op_sel_t;

   typedef enum logic {
      APU_TYPE_MULT = 1'b0,
      APU_TYPE_DIV  = 1'b1
   } apu_type_e;

   typedef enum logic [1:0] {
      IDLE = 2'd0,
      RUN  = 2'd1,
      DONE = 2'd2
   } div_state_e;

endpackage

`default_nettype wire
